// ==== design/mshr_pkg.sv ====
package mshr_pkg;

    localparam int LINE_ADDR_WIDTH = 26;
    localparam int TXNID_WIDTH     = 6;
    // entry id field sized for up to 16 entries
    localparam int ENTRY_ID_WIDTH  = 4;

    typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
    typedef logic [TXNID_WIDTH-1:0]     txnid_t;
    typedef logic [ENTRY_ID_WIDTH-1:0]  entry_id_t;

    // one outstanding line miss
    typedef struct packed {
        line_addr_t addr;
        txnid_t     txnid;
    } miss_req_t;

    // line request to the next level, tagged with its owner entry
    typedef struct packed {
        miss_req_t req;
        entry_id_t entry_id;
    } downstream_req_t;

    // per-entry life cycle
    typedef enum logic [1:0] {
        ENTRY_IDLE      = 2'd0,
        ENTRY_PEND      = 2'd1,
        ENTRY_WAIT_FILL = 2'd2
    } entry_state_t;

endpackage

// ==== design/mshr_entry_if.sv ====
interface mshr_entry_if
    import mshr_pkg::*;
#(
    parameter int ENTRY_NUM = 4
) ();

    // entry status with one bit per entry
    logic [ENTRY_NUM-1:0] busy;
    logic [ENTRY_NUM-1:0] req_vld;
    miss_req_t            req_pld [ENTRY_NUM];

    // one-hot allocation enable plus the shared request
    logic [ENTRY_NUM-1:0] alloc_en;
    miss_req_t            alloc_req;

    // one-hot grant back to the issuing entry
    logic [ENTRY_NUM-1:0] req_grant;

    modport alloc_side (
        input  busy,
        output alloc_en,
        output alloc_req
    );

    modport arb_side (
        input  req_vld,
        input  req_pld,
        output req_grant
    );

endinterface

// ==== design/mshr_alloc.sv ====
module mshr_alloc
    import mshr_pkg::*;
#(
    parameter int ENTRY_NUM = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             miss_vld,
    input  miss_req_t        miss_req,
    output logic             miss_rdy,
    output entry_id_t        alloc_index,
    mshr_entry_if.alloc_side ent
);

    localparam int CNT_WIDTH = $clog2(ENTRY_NUM + 1);

    logic                 free_found;
    entry_id_t            free_idx;
    logic                 alloc_fire;
    logic [ENTRY_NUM-1:0] busy_q;
    logic [ENTRY_NUM-1:0] busy_fall;
    logic [CNT_WIDTH-1:0] busy_cnt;
    logic                 full;

    // scan downward so the lowest free index is the one left standing
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
            if (!ent.busy[i]) begin
                free_found = 1'b1;
                free_idx   = entry_id_t'(i);
            end
        end
    end

    assign miss_rdy    = free_found;
    assign alloc_fire  = miss_vld && miss_rdy;
    assign alloc_index = free_idx;

    // one-hot write enable into the chosen entry
    always_comb begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            ent.alloc_en[i] = alloc_fire && (free_idx == entry_id_t'(i));
        end
    end

    assign ent.alloc_req = miss_req;

    // occupancy counter that sees released entries one cycle late
    assign busy_fall = busy_q & ~ent.busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q   <= '0;
            busy_cnt <= '0;
        end else begin
            busy_q   <= ent.busy;
            busy_cnt <= busy_cnt + CNT_WIDTH'(alloc_fire)
                        - CNT_WIDTH'($countones(busy_fall));
        end
    end

    assign full = (busy_cnt == CNT_WIDTH'(ENTRY_NUM));

endmodule

// ==== design/mshr_entry.sv ====
module mshr_entry
    import mshr_pkg::*;
#(
    parameter int ENTRY_ID = 0
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      alloc_en,
    input  miss_req_t alloc_req,
    input  logic      grant,
    input  logic      fill_vld,
    input  entry_id_t fill_entry_id,
    output logic      busy,
    output logic      req_vld,
    output miss_req_t req_pld
);

    entry_state_t state;
    miss_req_t    req_q;
    logic         fill_hit;

    // linefill ack addressed to this entry
    assign fill_hit = fill_vld && (fill_entry_id == entry_id_t'(ENTRY_ID));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENTRY_IDLE;
        end else begin
            case (state)
                ENTRY_IDLE: begin
                    if (alloc_en) begin
                        state <= ENTRY_PEND;
                    end
                end
                ENTRY_PEND: begin
                    // request accepted downstream
                    if (grant) begin
                        state <= ENTRY_WAIT_FILL;
                    end
                end
                ENTRY_WAIT_FILL: begin
                    if (fill_hit) begin
                        state <= ENTRY_IDLE;
                    end
                end
                default: begin
                    state <= ENTRY_IDLE;
                end
            endcase
        end
    end

    // miss address and txnid held for the life of the entry
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            req_q <= alloc_req;
        end
    end

    assign busy    = (state != ENTRY_IDLE);
    assign req_vld = (state == ENTRY_PEND);
    assign req_pld = req_q;

endmodule

// ==== design/mshr_req_arb.sv ====
module mshr_req_arb
    import mshr_pkg::*;
#(
    parameter int ENTRY_NUM = 4
) (
    input  logic            clk,
    input  logic            rst,
    mshr_entry_if.arb_side  ent,
    input  logic            downstream_rdy,
    output logic            downstream_vld,
    output downstream_req_t downstream_req
);

    entry_id_t ptr;
    logic      lock_vld;
    entry_id_t lock_idx;
    logic      rr_found;
    entry_id_t rr_idx;
    entry_id_t sel_idx;
    miss_req_t sel_req;
    logic      xfer;

    // round-robin search from ptr where the smallest offset wins
    always_comb begin
        int idx;
        rr_found = 1'b0;
        rr_idx   = '0;
        for (int off = ENTRY_NUM - 1; off >= 0; off--) begin
            idx = (int'(ptr) + off) % ENTRY_NUM;
            if (ent.req_vld[idx]) begin
                rr_found = 1'b1;
                rr_idx   = entry_id_t'(idx);
            end
        end
    end

    // a locked choice survives back-pressure untouched
    assign sel_idx        = lock_vld ? lock_idx : rr_idx;
    assign downstream_vld = lock_vld || rr_found;
    assign xfer           = downstream_vld && downstream_rdy;

    always_comb begin
        sel_req = '0;
        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (sel_idx == entry_id_t'(i)) begin
                sel_req = ent.req_pld[i];
            end
        end
    end

    assign downstream_req.req      = sel_req;
    assign downstream_req.entry_id = sel_idx;

    // grant pulse to the owner on transfer
    always_comb begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            ent.req_grant[i] = xfer && (sel_idx == entry_id_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lock_vld <= 1'b0;
            lock_idx <= '0;
        end else if (downstream_vld && !downstream_rdy) begin
            lock_vld <= 1'b1;
            lock_idx <= sel_idx;
        end else begin
            lock_vld <= 1'b0;
        end
    end

    // next search starts just past the winner
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (xfer) begin
            ptr <= entry_id_t'((int'(sel_idx) + 1) % ENTRY_NUM);
        end
    end

endmodule

// ==== design/icache_mshr_file.sv ====
module icache_mshr_file
    import mshr_pkg::*;
#(
    parameter int ENTRY_NUM = 4
) (
    input  logic       clk,
    input  logic       rst,

    // miss request in
    input  logic       miss_vld,
    input  line_addr_t miss_addr,
    input  txnid_t     miss_txnid,
    output logic       miss_rdy,
    output entry_id_t  alloc_index,

    // line request to next level
    output logic       downstream_vld,
    input  logic       downstream_rdy,
    output line_addr_t downstream_addr,
    output txnid_t     downstream_txnid,
    output entry_id_t  downstream_entry_id,

    // linefill ack
    input  logic       fill_vld,
    input  entry_id_t  fill_entry_id
);

    miss_req_t       miss_req;
    downstream_req_t downstream_req;

    mshr_entry_if #(
        .ENTRY_NUM (ENTRY_NUM)
    ) u_entry_if ();

    assign miss_req.addr  = miss_addr;
    assign miss_req.txnid = miss_txnid;

    mshr_alloc #(
        .ENTRY_NUM   (ENTRY_NUM)
    ) u_alloc (
        .clk         (clk),
        .rst         (rst),
        .miss_vld    (miss_vld),
        .miss_req    (miss_req),
        .miss_rdy    (miss_rdy),
        .alloc_index (alloc_index),
        .ent         (u_entry_if.alloc_side)
    );

    // entry i sits on bit i of every vector
    for (genvar i = 0; i < ENTRY_NUM; i++) begin : gen_entry
        mshr_entry #(
            .ENTRY_ID      (i)
        ) u_entry (
            .clk           (clk),
            .rst           (rst),
            .alloc_en      (u_entry_if.alloc_en[i]),
            .alloc_req     (u_entry_if.alloc_req),
            .grant         (u_entry_if.req_grant[i]),
            .fill_vld      (fill_vld),
            .fill_entry_id (fill_entry_id),
            .busy          (u_entry_if.busy[i]),
            .req_vld       (u_entry_if.req_vld[i]),
            .req_pld       (u_entry_if.req_pld[i])
        );
    end

    mshr_req_arb #(
        .ENTRY_NUM      (ENTRY_NUM)
    ) u_req_arb (
        .clk            (clk),
        .rst            (rst),
        .ent            (u_entry_if.arb_side),
        .downstream_rdy (downstream_rdy),
        .downstream_vld (downstream_vld),
        .downstream_req (downstream_req)
    );

    assign downstream_addr     = downstream_req.req.addr;
    assign downstream_txnid    = downstream_req.req.txnid;
    assign downstream_entry_id = downstream_req.entry_id;

endmodule

// ==== verification/icache_mshr_file_assertions.sv ====
module icache_mshr_file_assertions
    import mshr_pkg::*;
#(
    parameter int ENTRY_NUM = 4
) (
    input logic       clk,
    input logic       rst,
    input logic       downstream_vld,
    input logic       downstream_rdy,
    input line_addr_t downstream_addr,
    input txnid_t     downstream_txnid,
    input entry_id_t  downstream_entry_id,
    input logic       full
);

    // number of failed assertions
    int fail_count = 0;

    // stalled request keeps valid and payload
    payload_stable: assert property (@(posedge clk) disable iff (rst)
        downstream_vld && !downstream_rdy |=> downstream_vld && $stable(downstream_addr)
            && $stable(downstream_txnid) && $stable(downstream_entry_id))
        else begin
            $error("downstream payload changed under back-pressure");
            fail_count++;
        end

    clean_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !downstream_vld && !full)
        else begin
            $error("request valid or full flag set right after reset");
            fail_count++;
        end

    entry_id_range: assert property (@(posedge clk) disable iff (rst)
        downstream_vld |-> downstream_entry_id < entry_id_t'(ENTRY_NUM))
        else begin
            $error("downstream entry id out of range");
            fail_count++;
        end

endmodule

bind icache_mshr_file icache_mshr_file_assertions #(
    .ENTRY_NUM           (ENTRY_NUM)
) u_assertions (
    .clk                 (clk),
    .rst                 (rst),
    .downstream_vld      (downstream_vld),
    .downstream_rdy      (downstream_rdy),
    .downstream_addr     (downstream_addr),
    .downstream_txnid    (downstream_txnid),
    .downstream_entry_id (downstream_entry_id),
    .full                (u_alloc.full)
);

// ==== verification/tb_icache_mshr_file.sv ====
module tb_icache_mshr_file
    import mshr_pkg::*;
();

    localparam int ENTRY_NUM      = 4;
    localparam int TIMEOUT_CYCLES = 40;

    logic       clk;
    logic       rst;
    logic       miss_vld;
    line_addr_t miss_addr;
    txnid_t     miss_txnid;
    logic       miss_rdy;
    entry_id_t  alloc_index;
    logic       downstream_vld;
    logic       downstream_rdy;
    line_addr_t downstream_addr;
    txnid_t     downstream_txnid;
    entry_id_t  downstream_entry_id;
    logic       fill_vld;
    entry_id_t  fill_entry_id;

    integer          seed;
    downstream_req_t ds_seen;
    // occupancy model with one slot per entry
    logic            model_busy   [ENTRY_NUM];
    logic            model_issued [ENTRY_NUM];
    miss_req_t       model_req    [ENTRY_NUM];

    icache_mshr_file #(.ENTRY_NUM(ENTRY_NUM)) DUT (.*);

    assign ds_seen = {downstream_addr, downstream_txnid, downstream_entry_id};

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "control bit mismatch");
        end
    endtask

    task automatic check_entry_id(input string name, input entry_id_t exp, input entry_id_t act);
        if (act !== exp) begin
            $display("ERR %s: expected entry %0d, actual entry %0d", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "entry id mismatch");
        end
    endtask

    task automatic check_req(input string name, input downstream_req_t exp,
                             input downstream_req_t act);
        if (act !== exp) begin
            $display("ERR %s: expected addr %h txnid %h id %0d, actual addr %h txnid %h id %0d",
                     name, exp.req.addr, exp.req.txnid, exp.entry_id,
                     act.req.addr, act.req.txnid, act.entry_id);
            $display("Finished with errors");
            $fatal(1, "downstream request mismatch");
        end
    endtask

    task automatic report_timeout(input string name, input string what);
        $display("%s: gave up waiting for %s", name, what);
        $display("Finished with errors");
        $fatal(1, "wait timed out");
    endtask

    // lowest free entry in the model or -1 when full
    function automatic int model_lowest_free();
        int idx = -1;
        for (int i = ENTRY_NUM - 1; i >= 0; i--) begin
            if (!model_busy[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic send_miss(input string name, input int exp_idx);
        int cycles = 0;
        @(negedge clk);
        miss_vld   = 1'b1;
        miss_addr  = line_addr_t'($random(seed));
        miss_txnid = txnid_t'($random(seed));
        @(posedge clk);
        while (!miss_rdy) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout(name, "miss_rdy during a miss");
            end
            @(posedge clk);
        end
        check_entry_id(name, entry_id_t'(exp_idx), alloc_index);
        model_busy[exp_idx]   = 1'b1;
        model_issued[exp_idx] = 1'b0;
        model_req[exp_idx]    = {miss_addr, miss_txnid};
        @(negedge clk);
        miss_vld = 1'b0;
    endtask

    task automatic send_fill(input int id);
        @(negedge clk);
        fill_vld      = 1'b1;
        fill_entry_id = entry_id_t'(id);
        @(negedge clk);
        fill_vld         = 1'b0;
        model_busy[id]   = 1'b0;
        model_issued[id] = 1'b0;
    endtask

    task automatic wait_miss_rdy(input string name);
        int cycles = 0;
        @(posedge clk);
        while (!miss_rdy) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout(name, "miss_rdy to rise");
            end
            @(posedge clk);
        end
    endtask

    task automatic wait_downstream_vld(input string name);
        int cycles = 0;
        @(posedge clk);
        while (!downstream_vld) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout(name, "downstream_vld to rise");
            end
            @(posedge clk);
        end
    endtask

    // wait for a transfer and compare it with the model's stored miss
    task automatic expect_downstream(input string name, input int id);
        int cycles = 0;
        @(posedge clk);
        while (!(downstream_vld && downstream_rdy)) begin
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout(name, "a downstream transfer");
            end
            @(posedge clk);
        end
        check_req(name, {model_req[id], entry_id_t'(id)}, ds_seen);
        model_issued[id] = 1'b1;
    endtask

    task automatic reset_state();
        @(posedge clk);
        check_bit("reset_state miss_rdy", 1'b1, miss_rdy);
        check_bit("reset_state downstream_vld", 1'b0, downstream_vld);
    endtask

    task automatic alloc_lowest_free();
        @(negedge clk);
        downstream_rdy = 1'b0;
        for (int i = 0; i < ENTRY_NUM; i++) begin
            send_miss("alloc_lowest_free", i);
        end
        @(posedge clk);
        check_bit("alloc_lowest_free full", 1'b0, miss_rdy);
    endtask

    task automatic round_robin_issue();
        @(negedge clk);
        downstream_rdy = 1'b1;
        for (int i = 0; i < ENTRY_NUM; i++) begin
            expect_downstream("round_robin_issue", i);
        end
    endtask

    task automatic backpressure_hold();
        downstream_req_t held;
        @(negedge clk);
        downstream_rdy = 1'b0;
        send_fill(0);
        wait_miss_rdy("backpressure_hold");
        send_miss("backpressure_hold", 0);
        wait_downstream_vld("backpressure_hold");
        held = ds_seen;
        check_req("backpressure_hold", {model_req[0], entry_id_t'(0)}, held);
        repeat (5) begin
            @(posedge clk);
            check_bit("backpressure_hold vld", 1'b1, downstream_vld);
            check_req("backpressure_hold", held, ds_seen);
        end
        @(negedge clk);
        downstream_rdy = 1'b1;
        expect_downstream("backpressure_hold", 0);
    endtask

    task automatic fill_release_reuse();
        @(posedge clk);
        check_bit("fill_release_reuse full", 1'b0, miss_rdy);
        send_fill(2);
        wait_miss_rdy("fill_release_reuse");
        send_miss("fill_release_reuse", 2);
        expect_downstream("fill_release_reuse", 2);
    endtask

    task automatic random_traffic();
        int free_idx;
        int fill_idx;
        int ds_id;
        for (int cyc = 0; cyc < 400; cyc++) begin
            @(negedge clk);
            miss_vld       = 1'($random(seed));
            miss_addr      = line_addr_t'($random(seed));
            miss_txnid     = txnid_t'($random(seed));
            downstream_rdy = ({$random(seed)} % 4) != 0;
            // fills only go to entries already issued downstream
            fill_idx       = {$random(seed)} % ENTRY_NUM;
            fill_vld       = model_issued[fill_idx] && 1'($random(seed));
            fill_entry_id  = entry_id_t'(fill_idx);
            @(posedge clk);
            free_idx = model_lowest_free();
            ds_id    = int'(downstream_entry_id);
            check_bit("random_traffic miss_rdy", free_idx >= 0, miss_rdy);
            if (miss_vld && miss_rdy) begin
                check_entry_id("random_traffic", entry_id_t'(free_idx), alloc_index);
            end
            if (downstream_vld) begin
                check_bit("random_traffic pending", 1'b1,
                          model_busy[ds_id] && !model_issued[ds_id]);
            end
            if (downstream_vld && downstream_rdy) begin
                check_req("random_traffic", {model_req[ds_id], entry_id_t'(ds_id)}, ds_seen);
                model_issued[ds_id] = 1'b1;
            end
            if (fill_vld) begin
                model_busy[fill_idx]   = 1'b0;
                model_issued[fill_idx] = 1'b0;
            end
            if (miss_vld && miss_rdy) begin
                model_busy[free_idx]   = 1'b1;
                model_issued[free_idx] = 1'b0;
                model_req[free_idx]    = {miss_addr, miss_txnid};
            end
        end
        @(negedge clk);
        miss_vld = 1'b0;
        fill_vld = 1'b0;
    endtask

    initial begin
        seed           = 32'heb41_3896;
        rst            = 1'b1;
        miss_vld       = 1'b0;
        miss_addr      = '0;
        miss_txnid     = '0;
        downstream_rdy = 1'b0;
        fill_vld       = 1'b0;
        fill_entry_id  = '0;
        for (int i = 0; i < ENTRY_NUM; i++) begin
            model_busy[i]   = 1'b0;
            model_issued[i] = 1'b0;
            model_req[i]    = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_state();
        alloc_lowest_free();
        round_robin_issue();
        backpressure_hold();
        fill_release_reuse();
        random_traffic();

        if (DUT.u_assertions.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Finished with errors");
            $fatal(1, "bound assertions failed during the run");
        end
    end

endmodule

// ==== build.f ====
design/mshr_pkg.sv
design/mshr_entry_if.sv
design/mshr_alloc.sv
design/mshr_entry.sv
design/mshr_req_arb.sv
design/icache_mshr_file.sv
verification/icache_mshr_file_assertions.sv
verification/tb_icache_mshr_file.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the MSHR file testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module tb_icache_mshr_file \
        -Mdir obj_dir -f build.f; then
    echo "FAIL: Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_icache_mshr_file > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# the log decides, a crashed run counts as a failure too
if grep -q "Finished with errors" "$LOG"; then
    echo "FAIL: testbench reported errors"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "FAIL: simulation exited with status $run_status"
    exit 1
fi

echo "PASS"
exit 0
